//--- verilog/rsa_pkg.sv
package rsa_pkg;

	// default operand width of the engine
	localparam int RSA_WIDTH = 256;

	// iteration counters must reach RSA_WIDTH itself
	localparam int CNT_BITS = $clog2(RSA_WIDTH) + 1;

	// exponent FSM states
	// idle waits for a request
	// prep brings a into the Montgomery domain
	// mont runs product and square together
	// calc takes one exponent bit
	typedef enum logic [1:0] {
		S_IDLE = 2'b00,
		S_PREP = 2'b01,
		S_MONT = 2'b10,
		S_CALC = 2'b11
	} rsa_state_t;

endpackage

//--- verilog/rsa_ifs.sv
`timescale 1ns/1ps

// request from the input side into the core
interface rsa_req_if
	import rsa_pkg::*;
#(
	parameter int WIDTH = RSA_WIDTH
) ();
	logic             req_valid;
	logic             req_ready;
	logic [WIDTH-1:0] a;
	logic [WIDTH-1:0] d;
	logic [WIDTH-1:0] n;

	modport source (output req_valid, a, d, n, input req_ready);
	modport sink (input req_valid, a, d, n, output req_ready);
endinterface

// core to the modular product unit
interface rsa_prod_if
	import rsa_pkg::*;
#(
	parameter int WIDTH = RSA_WIDTH
) ();
	logic             start;
	logic [WIDTH-1:0] a;
	logic [WIDTH-1:0] n;
	logic [WIDTH-1:0] result;
	logic             done;

	modport core (output start, a, n, input result, done);
	modport unit (input start, a, n, output result, done);
endinterface

// core to one Montgomery multiplier
interface rsa_mont_if
	import rsa_pkg::*;
#(
	parameter int WIDTH = RSA_WIDTH
) ();
	logic             start;
	logic [WIDTH-1:0] a;
	logic [WIDTH-1:0] b;
	logic [WIDTH-1:0] n;
	logic [WIDTH-1:0] result;
	logic             done;

	modport core (output start, a, b, n, input result, done);
	modport unit (input start, a, b, n, output result, done);
endinterface

//--- verilog/rsa_in_stage.sv
`timescale 1ns/1ps

module rsa_in_stage
	import rsa_pkg::*;
#(
	parameter int WIDTH = RSA_WIDTH
) (
	input  logic             i_clk,
	input  logic             i_rst,
	input  logic             i_valid,
	output logic             o_ready,
	input  logic [WIDTH-1:0] i_a,
	input  logic [WIDTH-1:0] i_d,
	input  logic [WIDTH-1:0] i_n,
	rsa_req_if.source        req
);

logic             full;
logic [WIDTH-1:0] a_q;
logic [WIDTH-1:0] d_q;
logic [WIDTH-1:0] n_q;

// one entry, no bypass
assign o_ready = !full;

assign req.req_valid = full;
assign req.a = a_q;
assign req.d = d_q;
assign req.n = n_q;

always_ff @(posedge i_clk or posedge i_rst) begin
	if (i_rst) begin
		full <= 1'b0;
	end
	else if (i_valid && o_ready) begin
		full <= 1'b1;
	end
	else if (full && req.req_ready) begin
		// core took the operands
		full <= 1'b0;
	end
end

always_ff @(posedge i_clk) begin
	if (i_valid && o_ready) begin
		a_q <= i_a;
		d_q <= i_d;
		n_q <= i_n;
	end
end

endmodule

//--- verilog/rsa_mod_prod.sv
`timescale 1ns/1ps

module rsa_mod_prod
	import rsa_pkg::*;
#(
	parameter int WIDTH = RSA_WIDTH
) (
	input  logic     i_clk,
	input  logic     i_rst,
	rsa_prod_if.unit prod
);

logic                busy;
logic                done_q;
logic [CNT_BITS-1:0] cnt;
logic                last_step;
logic [WIDTH:0]      acc;
logic [WIDTH-1:0]    n_q;
logic [WIDTH-1:0]    acc_red;

// acc holds the doubled value and is reduced on the next step
assign acc_red = (acc >= {1'b0, n_q}) ? WIDTH'(acc - {1'b0, n_q}) : acc[WIDTH-1:0];

assign last_step = busy && (cnt == CNT_BITS'(WIDTH - 1));

// a * 2^WIDTH mod n once done is up
assign prod.result = acc_red;
assign prod.done = done_q;

always_ff @(posedge i_clk or posedge i_rst) begin
	if (i_rst) begin
		busy <= 1'b0;
		done_q <= 1'b0;
		cnt <= '0;
	end
	else begin
		done_q <= 1'b0;
		if (prod.start) begin
			busy <= 1'b1;
			cnt <= '0;
		end
		else if (busy) begin
			cnt <= cnt + 1'b1;
			if (last_step) begin
				busy <= 1'b0;
				done_q <= 1'b1;
			end
		end
	end
end

always_ff @(posedge i_clk) begin
	if (prod.start) begin
		acc <= {1'b0, prod.a};
		n_q <= prod.n;
	end
	else if (busy) begin
		acc <= {acc_red, 1'b0};
	end
end

endmodule

//--- verilog/rsa_mont.sv
`timescale 1ns/1ps

module rsa_mont
	import rsa_pkg::*;
#(
	parameter int WIDTH = RSA_WIDTH
) (
	input  logic     i_clk,
	input  logic     i_rst,
	rsa_mont_if.unit mont
);

logic                busy;
logic                done_q;
logic [CNT_BITS-1:0] cnt;
logic                sub_step;
logic                a_bit;
logic [WIDTH-1:0]    a_q;
logic [WIDTH+1:0]    acc;
logic [WIDTH+1:0]    acc_in;
logic [WIDTH+1:0]    sum_b;
logic [WIDTH+1:0]    sum_n;
logic [WIDTH+1:0]    acc_red;

// first add-and-halve step runs in the start cycle
assign a_bit = mont.start ? mont.a[0] : a_q[0];
assign acc_in = mont.start ? '0 : acc;

// b and n are held by the core until done
assign sum_b = a_bit ? acc_in + {2'b00, mont.b} : acc_in;
assign sum_n = sum_b[0] ? sum_b + {2'b00, mont.n} : sum_b;

// acc stays below 2n so one subtraction is enough
assign acc_red = (acc >= {2'b00, mont.n}) ? acc - {2'b00, mont.n} : acc;

assign sub_step = busy && (cnt == CNT_BITS'(WIDTH));

assign mont.result = acc[WIDTH-1:0];
assign mont.done = done_q;

always_ff @(posedge i_clk or posedge i_rst) begin
	if (i_rst) begin
		busy <= 1'b0;
		done_q <= 1'b0;
		cnt <= '0;
	end
	else begin
		done_q <= 1'b0;
		if (mont.start) begin
			busy <= 1'b1;
			cnt <= CNT_BITS'(1);
		end
		else if (sub_step) begin
			busy <= 1'b0;
			done_q <= 1'b1;
		end
		else if (busy) begin
			cnt <= cnt + 1'b1;
		end
	end
end

always_ff @(posedge i_clk) begin
	if (mont.start) begin
		acc <= sum_n >> 1;
		a_q <= mont.a >> 1;
	end
	else if (sub_step) begin
		acc <= acc_red;
	end
	else if (busy) begin
		acc <= sum_n >> 1;
		a_q <= a_q >> 1;
	end
end

endmodule

//--- verilog/rsa256_core.sv
`timescale 1ns/1ps

module rsa256_core
	import rsa_pkg::*;
#(
	parameter int WIDTH = RSA_WIDTH
) (
	input  logic             i_clk,
	input  logic             i_rst,
	rsa_req_if.sink          req,
	output logic             o_res_valid,
	input  logic             i_res_ready,
	output logic [WIDTH-1:0] o_result
);

rsa_state_t          state, state_nxt;
logic [CNT_BITS-1:0] bit_cnt;
logic                last_bit;
logic                take_req;
logic                calc_adv;
logic                prod_start, prod_start_nxt;
logic                mont_start, mont_start_nxt;
logic [WIDTH-1:0]    a_q;
logic [WIDTH-1:0]    d_q;
logic [WIDTH-1:0]    n_q;
// running value, plain domain
logic [WIDTH-1:0]    m;
// running square, Montgomery domain
logic [WIDTH-1:0]    t;

rsa_prod_if #(.WIDTH(WIDTH)) prod_bus ();
rsa_mont_if #(.WIDTH(WIDTH)) mul_bus ();
rsa_mont_if #(.WIDTH(WIDTH)) sqr_bus ();

rsa_mod_prod #(.WIDTH(WIDTH)) u_prep (.i_clk(i_clk), .i_rst(i_rst), .prod(prod_bus.unit));
rsa_mont #(.WIDTH(WIDTH)) u_mul (.i_clk(i_clk), .i_rst(i_rst), .mont(mul_bus.unit));
rsa_mont #(.WIDTH(WIDTH)) u_sqr (.i_clk(i_clk), .i_rst(i_rst), .mont(sqr_bus.unit));

assign req.req_ready = (state == S_IDLE);
assign take_req = req.req_valid && req.req_ready;
assign last_bit = (bit_cnt == CNT_BITS'(WIDTH - 1));
assign calc_adv = (state == S_CALC) && !last_bit;

// operands stay in registers while the units run
assign prod_bus.start = prod_start;
assign prod_bus.a = a_q;
assign prod_bus.n = n_q;

assign mul_bus.start = mont_start;
assign mul_bus.a = m;
assign mul_bus.b = t;
assign mul_bus.n = n_q;

assign sqr_bus.start = mont_start;
assign sqr_bus.a = t;
assign sqr_bus.b = t;
assign sqr_bus.n = n_q;

// last bit folds into the result without a register update
assign o_res_valid = (state == S_CALC) && last_bit;
assign o_result = d_q[0] ? mul_bus.result : m;

always_comb begin
	state_nxt = state;
	prod_start_nxt = 1'b0;
	mont_start_nxt = 1'b0;
	case (state)
		S_IDLE: begin
			if (take_req) begin
				state_nxt = S_PREP;
				prod_start_nxt = 1'b1;
			end
		end
		S_PREP: begin
			if (prod_bus.done) begin
				state_nxt = S_MONT;
				mont_start_nxt = 1'b1;
			end
		end
		S_MONT: begin
			if (mul_bus.done && sqr_bus.done) begin
				state_nxt = S_CALC;
			end
		end
		S_CALC: begin
			if (!last_bit) begin
				state_nxt = S_MONT;
				mont_start_nxt = 1'b1;
			end
			else if (i_res_ready) begin
				state_nxt = S_IDLE;
			end
		end
	endcase
end

always_ff @(posedge i_clk or posedge i_rst) begin
	if (i_rst) begin
		state <= S_IDLE;
		prod_start <= 1'b0;
		mont_start <= 1'b0;
		bit_cnt <= '0;
	end
	else begin
		state <= state_nxt;
		prod_start <= prod_start_nxt;
		mont_start <= mont_start_nxt;
		if (take_req) begin
			bit_cnt <= '0;
		end
		else if (calc_adv) begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end
end

always_ff @(posedge i_clk) begin
	if (take_req) begin
		a_q <= req.a;
		d_q <= req.d;
		n_q <= req.n;
	end
	if ((state == S_PREP) && prod_bus.done) begin
		t <= prod_bus.result;
		m <= WIDTH'(1);
	end
	if (calc_adv) begin
		t <= sqr_bus.result;
		if (d_q[0]) begin
			m <= mul_bus.result;
		end
		d_q <= d_q >> 1;
	end
end

endmodule

//--- verilog/rsa_out_stage.sv
`timescale 1ns/1ps

module rsa_out_stage
	import rsa_pkg::*;
#(
	parameter int WIDTH = RSA_WIDTH
) (
	input  logic             i_clk,
	input  logic             i_rst,
	input  logic             i_res_valid,
	output logic             o_res_ready,
	input  logic [WIDTH-1:0] i_result,
	output logic             o_valid,
	input  logic             i_ready,
	output logic [WIDTH-1:0] o_a_pow_d
);

logic full;

assign o_res_ready = !full;
assign o_valid = full;

always_ff @(posedge i_clk or posedge i_rst) begin
	if (i_rst) begin
		full <= 1'b0;
	end
	else if (i_res_valid && o_res_ready) begin
		full <= 1'b1;
	end
	else if (full && i_ready) begin
		full <= 1'b0;
	end
end

// held stable until the consumer takes it
always_ff @(posedge i_clk) begin
	if (i_res_valid && o_res_ready) begin
		o_a_pow_d <= i_result;
	end
end

endmodule

//--- verilog/rsa256_top.sv
`timescale 1ns/1ps

module rsa256_top
	import rsa_pkg::*;
#(
	parameter int WIDTH = RSA_WIDTH
) (
	input  logic             i_clk,
	input  logic             i_rst,
	input  logic             i_valid,
	output logic             o_ready,
	input  logic [WIDTH-1:0] i_a,
	input  logic [WIDTH-1:0] i_d,
	input  logic [WIDTH-1:0] i_n,
	output logic             o_valid,
	input  logic             i_ready,
	output logic [WIDTH-1:0] o_a_pow_d
);

logic             res_valid;
logic             res_ready;
logic [WIDTH-1:0] result;

rsa_req_if #(.WIDTH(WIDTH)) req_bus ();

rsa_in_stage #(.WIDTH(WIDTH)) u_in (
	.i_clk   (i_clk),
	.i_rst   (i_rst),
	.i_valid (i_valid),
	.o_ready (o_ready),
	.i_a     (i_a),
	.i_d     (i_d),
	.i_n     (i_n),
	.req     (req_bus.source)
);

rsa256_core #(.WIDTH(WIDTH)) u_core (
	.i_clk       (i_clk),
	.i_rst       (i_rst),
	.req         (req_bus.sink),
	.o_res_valid (res_valid),
	.i_res_ready (res_ready),
	.o_result    (result)
);

rsa_out_stage #(.WIDTH(WIDTH)) u_out (
	.i_clk       (i_clk),
	.i_rst       (i_rst),
	.i_res_valid (res_valid),
	.o_res_ready (res_ready),
	.i_result    (result),
	.o_valid     (o_valid),
	.i_ready     (i_ready),
	.o_a_pow_d   (o_a_pow_d)
);

endmodule

//--- verification/rsa256_tb.sv
`timescale 1ns/1ps

module rsa256_tb
	import rsa_pkg::*;
();

localparam int W = RSA_WIDTH;
localparam int NUM_DIRECTED = 4;
localparam int NUM_RANDOM = 20;
localparam longint WATCHDOG_CYCLES =
	longint'(NUM_DIRECTED + NUM_RANDOM) * (W + 3) * (W + 2) + 50000;

typedef logic [W-1:0] word_t;

logic  i_clk;
logic  i_rst;
logic  i_valid;
logic  o_ready;
word_t i_a;
word_t i_d;
word_t i_n;
logic  o_valid;
logic  i_ready;
word_t o_a_pow_d;

integer seed = 32'h97ee_ab2c;
int     ready_mode;
int     sent_cnt;
int     got_cnt;
int     stall_cnt;
word_t  exp_q[$];
word_t  rnd_a[NUM_RANDOM];
word_t  rnd_d[NUM_RANDOM];
word_t  rnd_n[NUM_RANDOM];

rsa256_top #(.WIDTH(W)) uut (
	.i_clk     (i_clk),
	.i_rst     (i_rst),
	.i_valid   (i_valid),
	.o_ready   (o_ready),
	.i_a       (i_a),
	.i_d       (i_d),
	.i_n       (i_n),
	.o_valid   (o_valid),
	.i_ready   (i_ready),
	.o_a_pow_d (o_a_pow_d)
);

task automatic abort_run(string why);
	$display("%s", why);
	$display("** FAIL **");
	$fatal(1, "simulation stopped on error");
endtask

task automatic check_value(string name, word_t expected, word_t actual);
	assert (actual === expected) else
		abort_run($sformatf("ERR %0t %s expected %h got %h", $time, name, expected, actual));
endtask

// shift-and-add product where x must be below n
function automatic word_t mul_mod(word_t x, word_t y, word_t n);
	logic [W+1:0] r;
	r = '0;
	for (int i = W - 1; i >= 0; i--) begin
		r = r << 1;
		if (r >= {2'b00, n})
			r = r - {2'b00, n};
		if (y[i])
			r = r + {2'b00, x};
		if (r >= {2'b00, n})
			r = r - {2'b00, n};
	end
	return r[W-1:0];
endfunction

// square and multiply starting from the lsb
function automatic word_t pow_mod(word_t a, word_t d, word_t n);
	word_t r;
	word_t b;
	r = word_t'(1);
	b = a;
	for (int i = 0; i < W; i++) begin
		if (d[i])
			r = mul_mod(r, b, n);
		b = mul_mod(b, b, n);
	end
	return r;
endfunction

task automatic rand_word(output word_t v);
	v = '0;
	for (int i = 0; i < W / 32; i++) begin
		v = {v[W-33:0], 32'($random(seed))};
	end
endtask

// entered and left 1 ns after a rising edge
task automatic send_req(word_t a, word_t d, word_t n, word_t expected);
	logic taken;
	exp_q.push_back(expected);
	sent_cnt++;
	i_valid = 1'b1;
	i_a = a;
	i_d = d;
	i_n = n;
	do begin
		taken = o_ready;
		@(posedge i_clk);
		#1;
	end while (!taken);
	i_valid = 1'b0;
endtask

task automatic wait_results();
	while (got_cnt != sent_cnt) begin
		@(posedge i_clk);
		#1;
	end
endtask

initial begin
	i_clk = 1'b0;
	forever #5 i_clk = ~i_clk;
end

// consumer ready per mode
// 0 always ready
// 1 held off
// 2 random
initial begin
	forever begin
		@(posedge i_clk);
		#1;
		case (ready_mode)
			0: i_ready = 1'b1;
			1: i_ready = 1'b0;
			default: i_ready = (($random(seed) & 3) == 0);
		endcase
	end
end

// handshake values are stable at the falling edge
always @(negedge i_clk) begin
	if (!i_rst && i_valid && !o_ready)
		stall_cnt++;
	if (!i_rst && o_valid && i_ready) begin
		if (exp_q.size() == 0) begin
			abort_run("output handshake with no request outstanding");
		end
		else begin
			got_cnt++;
			check_value("o_a_pow_d", exp_q.pop_front(), o_a_pow_d);
		end
	end
end

hold_under_stall: assert property (@(posedge i_clk) disable iff (i_rst)
	(o_valid && !i_ready) |=> (o_valid && $stable(o_a_pow_d)))
	else abort_run("output changed while the consumer was stalled");

in_stage_full: assert property (@(posedge i_clk) disable iff (i_rst)
	(i_valid && o_ready) |=> !o_ready)
	else abort_run("o_ready stayed high after the input stage took a request");

initial begin
	repeat (WATCHDOG_CYCLES) @(posedge i_clk);
	abort_run($sformatf("timeout, %0d of %0d results seen, core in %s",
		got_cnt, sent_cnt, uut.u_core.state.name()));
end

initial begin
	word_t ra;
	word_t rd;
	word_t rn;
	i_rst = 1'b1;
	i_valid = 1'b0;
	i_ready = 1'b1;
	i_a = '0;
	i_d = '0;
	i_n = '0;
	ready_mode = 0;
	sent_cnt = 0;
	got_cnt = 0;
	stall_cnt = 0;
	// random operands come first in the seeded stream
	for (int k = 0; k < NUM_RANDOM; k++) begin
		rand_word(rn);
		rn[W-1] = 1'b1;
		rn[0] = 1'b1;
		rand_word(ra);
		rand_word(rd);
		rnd_n[k] = rn;
		rnd_a[k] = ra % rn;
		rnd_d[k] = rd;
	end
	repeat (3) @(posedge i_clk);
	#1;
	i_rst = 1'b0;
	check_value("o_valid", word_t'(0), word_t'(o_valid));
	check_value("o_ready", word_t'(1), word_t'(o_ready));
	check_value("pow_mod", word_t'(1024), pow_mod(word_t'(2), word_t'(10), word_t'(1000003)));

	// directed vectors sent one at a time
	send_req(word_t'(12345), word_t'(0), word_t'(1000003), word_t'(1));
	wait_results();
	send_req(word_t'(987654), word_t'(1), word_t'(1000003), word_t'(987654));
	wait_results();
	send_req(word_t'(2), word_t'(10), word_t'(1000003), word_t'(1024));
	wait_results();
	send_req(word_t'(7), word_t'(65537), word_t'(3233),
		pow_mod(word_t'(7), word_t'(65537), word_t'(3233)));
	wait_results();

	// fill all three stages with the consumer held off
	ready_mode = 1;
	for (int k = 0; k < 3; k++) begin
		send_req(rnd_a[k], rnd_d[k], rnd_n[k], pow_mod(rnd_a[k], rnd_d[k], rnd_n[k]));
	end
	do begin
		@(posedge i_clk);
		#1;
	end while (!(o_valid && uut.u_core.o_res_valid));
	check_value("o_ready", word_t'(0), word_t'(o_ready));

	ready_mode = 2;
	for (int k = 3; k < NUM_RANDOM; k++) begin
		send_req(rnd_a[k], rnd_d[k], rnd_n[k], pow_mod(rnd_a[k], rnd_d[k], rnd_n[k]));
	end
	wait_results();

	if (exp_q.size() == 0 && stall_cnt > 0) begin
		$display("** PASS **");
		$finish;
	end
	else begin
		abort_run("results left over or the input stage never stalled");
	end
end

endmodule

//--- filelist.f
verilog/rsa_pkg.sv
verilog/rsa_ifs.sv
verilog/rsa_in_stage.sv
verilog/rsa_mod_prod.sv
verilog/rsa_mont.sv
verilog/rsa256_core.sv
verilog/rsa_out_stage.sv
verilog/rsa256_top.sv
verification/rsa256_tb.sv

//--- Makefile
# Verilator build and run for the RSA-256 engine

VERILATOR ?= verilator
TOP       ?= rsa256_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	-./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
